//--- warehouse_trace.txt
# L loc shape colour angle : load a slot over UART, all hex; J byte : raw byte with no header
# S colour shape x y direction : search with expected result; T v : expected system_start
L 03 1 1 1
L 05 1 1 4
L 0A 2 4 2
L 0C 1 1 8
S 1 1 0FD 3C 000
S 1 1 0D2 96 400
S 1 1 0A0 19 C00
S 1 1 000 00 000
S 4 2 0A5 6E 800
L 19 1 1 1
T 0
S 1 1 000 00 000
L 1F 0 0 0
T 1
J 3C
J E7
L 14 8 8 3
S 8 8 04B 1E 003
T 1

//--- tb.f
warehouse_pkg.sv
uart_byte_rx.sv
slot_packet.sv
slot_table.sv
slot_search.sv
warehouse.sv
tb_clock_gen.sv
warehouse_asserts.sv
tb_warehouse.sv

//--- tb_warehouse.sv
`timescale 1ns/1ps
`default_nettype none

module tb_warehouse;

    import warehouse_pkg::*;

    localparam int CLKS_PER_BIT = 8;
    localparam int PERIOD_NS    = 4;
    localparam int RST_CYCLES   = 16;
    localparam int IDLE_CYCLES  = 4;  // gap after each packet
    localparam int SEARCH_LIMIT = SLOT_COUNT + 12;
    localparam int CMD_CYCLES   = 3 * 10 * CLKS_PER_BIT + IDLE_CYCLES + SEARCH_LIMIT;
    localparam int MAX_CMDS     = 64;

    logic              sys_clk;
    logic              sys_rst_n;
    logic [CODE_W-1:0] color;
    logic [CODE_W-1:0] shape;
    logic              en_flag;
    logic              uart_rx;
    wire  [X_W-1:0]    x_warehouse;
    wire  [Y_W-1:0]    y_warehouse;
    wire  [DIR_W-1:0]  direction;
    wire               ready_flag;
    wire               system_start;

    byte         op_mem [MAX_CMDS];
    logic [11:0] arg_mem [MAX_CMDS][5];
    int          n_cmds;
    int          errors;
    int          tests;
    int          assert_fails;
    longint      watchdog_ns;

    tb_clock_gen #(
        .HALF_NS    (PERIOD_NS / 2),
        .RST_CYCLES (RST_CYCLES)
    ) tb_clock_gen_inst (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n)
    );

    warehouse #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) warehouse_inst (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .color        (color),
        .shape        (shape),
        .en_flag      (en_flag),
        .uart_rx      (uart_rx),
        .x_warehouse  (x_warehouse),
        .y_warehouse  (y_warehouse),
        .direction    (direction),
        .ready_flag   (ready_flag),
        .system_start (system_start)
    );

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [11:0] a [5];
        fd = $fopen("warehouse_trace.txt", "r");
        n_cmds = 0;
        if (fd == 0) begin
            $display("cannot open warehouse_trace.txt");
            return;
        end
        while (!$feof(fd) && n_cmds < MAX_CMDS) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                a = '{default: '0};
                n = $sscanf(line, "%c %h %h %h %h %h", op, a[0], a[1], a[2], a[3], a[4]);
                op_mem[n_cmds]  = op;
                arg_mem[n_cmds] = a;
                n_cmds++;
            end
        end
        $fclose(fd);
    endtask

    // 8N1, lsb first, entered and left on a falling edge
    task automatic send_byte(input logic [7:0] b);
        uart_rx = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
        for (int i = 0; i < 8; i++) begin
            uart_rx = b[i];
            repeat (CLKS_PER_BIT) @(negedge sys_clk);
        end
        uart_rx = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
    endtask

    task automatic send_packet(input logic [LOC_W-1:0] loc, input logic [CODE_W-1:0] shp,
                               input logic [CODE_W-1:0] col, input logic [CODE_W-1:0] ang);
        send_byte({PKT_HDR, loc});
        send_byte({shp, col});
        send_byte({4'h0, ang});
        repeat (IDLE_CYCLES) @(negedge sys_clk);  // let the table take the load
        $display("test %0d: load location %h sent", tests, loc);
    endtask

    task automatic run_search(input logic [CODE_W-1:0] c, input logic [CODE_W-1:0] s,
                              input logic [X_W-1:0] ex, input logic [Y_W-1:0] ey,
                              input logic [DIR_W-1:0] ed);
        int cycles;
        int high_cnt;
        int errs;
        bit done;
        cycles   = 0;
        high_cnt = 0;
        errs     = 0;
        done     = 1'b0;
        color    = c;
        shape    = s;
        en_flag  = 1'b1;
        while (!done && cycles < SEARCH_LIMIT) begin
            @(negedge sys_clk);
            cycles++;
            en_flag = (cycles == 2);  // repeated request mid-search
            if (ready_flag) begin
                high_cnt++;
                if (x_warehouse !== ex) begin
                    $display("** Error x_warehouse: got 0x%h, expected 0x%h", x_warehouse, ex);
                    errs++;
                end
                if (y_warehouse !== ey) begin
                    $display("** Error y_warehouse: got 0x%h, expected 0x%h", y_warehouse, ey);
                    errs++;
                end
                if (direction !== ed) begin
                    $display("** Error direction: got 0x%h, expected 0x%h", direction, ed);
                    errs++;
                end
            end else if (high_cnt > 0) begin
                done = 1'b1;
            end
        end
        en_flag = 1'b0;
        if (!done) begin
            $display("search gave no complete ready pulse within %0d cycles", SEARCH_LIMIT);
            errs++;
        end else if (high_cnt != 2) begin
            $display("ready_flag stayed high for %0d cycles instead of 2", high_cnt);
            errs++;
        end
        @(negedge sys_clk);  // tail cycle back to idle
        errors += errs;
        $display("test %0d: search colour %h shape %h %s", tests, c, s,
                 (errs == 0) ? "pass" : "FAIL");
    endtask

    task automatic check_start(input logic exp);
        if (system_start !== exp) begin
            $display("** Error system_start: got 0x%h, expected 0x%h", system_start, exp);
            errors++;
        end
        $display("test %0d: system_start check done", tests);
    endtask

    task automatic run_command(input int i);
        logic [11:0] a [5];
        a = arg_mem[i];
        tests++;
        case (op_mem[i])
            "L": send_packet(a[0][LOC_W-1:0], a[1][CODE_W-1:0], a[2][CODE_W-1:0],
                             a[3][CODE_W-1:0]);
            "J": begin
                send_byte(a[0][7:0]);  // no header, must be dropped
                $display("test %0d: raw byte %h sent", tests, a[0][7:0]);
            end
            "S": run_search(a[0][CODE_W-1:0], a[1][CODE_W-1:0], a[2][X_W-1:0],
                            a[3][Y_W-1:0], a[4][DIR_W-1:0]);
            "T": check_start(a[0][0]);
            default: begin
                $display("unknown command in trace line %0d", i);
                errors++;
            end
        endcase
    endtask

    initial begin
        color       = '0;
        shape       = '0;
        en_flag     = 1'b0;
        uart_rx     = 1'b1;
        errors      = 0;
        tests       = 0;
        watchdog_ns = 0;
        load_trace();
        if (n_cmds == 0) begin
            $display("no commands read from the trace file");
            $display("Test FAILED");
            $finish;
        end else begin
            watchdog_ns = longint'(RST_CYCLES + 8 + n_cmds * CMD_CYCLES) * PERIOD_NS;
            wait (sys_rst_n === 1'b1);
            @(negedge sys_clk);
            tests++;
            if (ready_flag !== 1'b0 || system_start !== 1'b0) begin
                $display("** Error after reset: ready_flag 0x%h, system_start 0x%h, expected 0x0",
                         ready_flag, system_start);
                errors++;
            end
            $display("test %0d: reset state check done", tests);
            for (int i = 0; i < n_cmds; i++) begin
                run_command(i);
            end
            assert_fails = warehouse_inst.warehouse_asserts_inst.fail_count;
            $display("%0d tests, %0d check errors, %0d assertion failures",
                     tests, errors, assert_fails);
            if (errors == 0 && assert_fails == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, a load or search never finished", watchdog_ns);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- warehouse_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module warehouse_asserts (
    input wire                              sys_clk,
    input wire                              sys_rst_n,
    input wire                              en_flag,
    input wire [warehouse_pkg::X_W-1:0]     x_warehouse,
    input wire [warehouse_pkg::Y_W-1:0]     y_warehouse,
    input wire [warehouse_pkg::DIR_W-1:0]   direction,
    input wire                              ready_flag,
    input wire                              system_start
);

    int   fail_count = 0;
    logic req_seen;  // en_flag sampled since the last ready pulse

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            req_seen <= 1'b0;
        end else if (ready_flag) begin
            req_seen <= 1'b0;
        end else if (en_flag) begin
            req_seen <= 1'b1;
        end
    end

    ready_two_cycles: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $rose(ready_flag) |=> ready_flag ##1 !ready_flag)
        else begin
            fail_count++;
            $error("ready_flag pulse is not exactly 2 cycles");
        end

    outputs_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        ready_flag && $past(ready_flag) |->
            $stable(x_warehouse) && $stable(y_warehouse) && $stable(direction))
        else begin
            fail_count++;
            $error("result outputs changed while ready_flag high");
        end

    // a request made mid-search must not bring a second pulse
    pulse_needs_request: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $rose(ready_flag) |-> req_seen)
        else begin
            fail_count++;
            $error("ready_flag rose with no en_flag since the previous pulse");
        end

    start_sticky: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        system_start |=> system_start)
        else begin
            fail_count++;
            $error("system_start fell after rising");
        end

endmodule

bind warehouse warehouse_asserts warehouse_asserts_inst (.*);

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_NS    = 2,
    parameter int RST_CYCLES = 16
) (
    output logic sys_clk,
    output logic sys_rst_n
);

    initial begin
        sys_clk = 1'b0;
        forever #(HALF_NS) sys_clk = ~sys_clk;
    end

    initial begin
        sys_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge sys_clk);
        @(negedge sys_clk);  // release away from the sampling edge
        sys_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- warehouse.sv
`timescale 1ns/1ps
`default_nettype none

module warehouse #(
    parameter int CLKS_PER_BIT = 434
) (
    input  wire                               sys_clk,
    input  wire                               sys_rst_n,
    input  wire  [warehouse_pkg::CODE_W-1:0]  color,
    input  wire  [warehouse_pkg::CODE_W-1:0]  shape,
    input  wire                               en_flag,
    input  wire                               uart_rx,
    output wire  [warehouse_pkg::X_W-1:0]     x_warehouse,
    output wire  [warehouse_pkg::Y_W-1:0]     y_warehouse,
    output wire  [warehouse_pkg::DIR_W-1:0]   direction,
    output wire                               ready_flag,
    output wire                               system_start
);

    import warehouse_pkg::*;

    wire [7:0]        rx_byte;
    wire              rx_strobe;
    wire [LOC_W-1:0]  load_loc;
    wire [CODE_W-1:0] load_shape;
    wire [CODE_W-1:0] load_color;
    wire [CODE_W-1:0] load_angle;
    wire              load_valid;
    wire [LOC_W-1:0]  scan_index;
    wire              claim;
    wire [CODE_W-1:0] slot_color;
    wire [CODE_W-1:0] slot_shape;
    wire [CODE_W-1:0] slot_angle;
    wire              slot_used;

    uart_byte_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_byte_rx_inst (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .uart_rx   (uart_rx),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe)
    );

    slot_packet slot_packet_inst (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .rx_byte    (rx_byte),
        .rx_strobe  (rx_strobe),
        .load_loc   (load_loc),
        .load_shape (load_shape),
        .load_color (load_color),
        .load_angle (load_angle),
        .load_valid (load_valid)
    );

    slot_table slot_table_inst (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .load_loc     (load_loc),
        .load_shape   (load_shape),
        .load_color   (load_color),
        .load_angle   (load_angle),
        .load_valid   (load_valid),
        .scan_index   (scan_index),
        .claim        (claim),
        .slot_color   (slot_color),
        .slot_shape   (slot_shape),
        .slot_angle   (slot_angle),
        .slot_used    (slot_used),
        .system_start (system_start)
    );

    slot_search slot_search_inst (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .color       (color),
        .shape       (shape),
        .en_flag     (en_flag),
        .slot_color  (slot_color),
        .slot_shape  (slot_shape),
        .slot_angle  (slot_angle),
        .slot_used   (slot_used),
        .scan_index  (scan_index),
        .claim       (claim),
        .x_warehouse (x_warehouse),
        .y_warehouse (y_warehouse),
        .direction   (direction),
        .ready_flag  (ready_flag)
    );

endmodule

`default_nettype wire

//--- slot_search.sv
`timescale 1ns/1ps
`default_nettype none

module slot_search (
    input  wire                               sys_clk,
    input  wire                               sys_rst_n,
    input  wire  [warehouse_pkg::CODE_W-1:0]  color,
    input  wire  [warehouse_pkg::CODE_W-1:0]  shape,
    input  wire                               en_flag,
    input  wire  [warehouse_pkg::CODE_W-1:0]  slot_color,
    input  wire  [warehouse_pkg::CODE_W-1:0]  slot_shape,
    input  wire  [warehouse_pkg::CODE_W-1:0]  slot_angle,
    input  wire                               slot_used,
    output logic [warehouse_pkg::LOC_W-1:0]   scan_index,
    output logic                              claim,
    output logic [warehouse_pkg::X_W-1:0]     x_warehouse,
    output logic [warehouse_pkg::Y_W-1:0]     y_warehouse,
    output logic [warehouse_pkg::DIR_W-1:0]   direction,
    output logic                              ready_flag
);

    import warehouse_pkg::*;

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_SCAN = 3'd1;
    localparam logic [2:0] S_MAP  = 3'd2;
    localparam logic [2:0] S_RDY1 = 3'd3;
    localparam logic [2:0] S_RDY2 = 3'd4;
    localparam logic [2:0] S_TAIL = 3'd5;

    logic [2:0]        state;
    logic [CODE_W-1:0] color_q;
    logic [CODE_W-1:0] shape_q;
    logic              match;
    logic [LOC_W-1:0]  slot_idx;

    assign match    = (slot_color == color_q) && (slot_shape == shape_q) && !slot_used;
    assign claim    = (state == S_SCAN) && match;
    assign slot_idx = scan_index - LOC_W'(1);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state       <= S_IDLE;
            color_q     <= '0;
            shape_q     <= '0;
            scan_index  <= '0;
            x_warehouse <= '0;
            y_warehouse <= '0;
            direction   <= '0;
            ready_flag  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (en_flag) begin
                        color_q     <= color;
                        shape_q     <= shape;
                        scan_index  <= LOC_W'(1);
                        x_warehouse <= '0;  // miss leaves zeros
                        y_warehouse <= '0;
                        direction   <= '0;
                        state       <= S_SCAN;
                    end
                end
                S_SCAN: begin
                    if (match) begin
                        x_warehouse <= SLOT_X[slot_idx];
                        y_warehouse <= SLOT_Y[slot_idx];
                        direction   <= DIR_W'(slot_angle);  // raw angle, mapped next
                        scan_index  <= '0;
                        state       <= S_MAP;
                    end else if (scan_index == LOC_W'(SLOT_COUNT)) begin
                        scan_index <= '0;
                        state      <= S_MAP;
                    end else begin
                        scan_index <= scan_index + LOC_W'(1);
                    end
                end
                S_MAP: begin
                    case (direction)
                        DIR_W'(1): direction <= DIR_0;
                        DIR_W'(2): direction <= DIR_180;
                        DIR_W'(4): direction <= DIR_90;
                        DIR_W'(8): direction <= DIR_270;
                        default:   direction <= direction;  // other codes pass through
                    endcase
                    ready_flag <= 1'b1;
                    state      <= S_RDY1;
                end
                S_RDY1: state <= S_RDY2;
                S_RDY2: begin
                    ready_flag <= 1'b0;
                    state      <= S_TAIL;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- slot_table.sv
`timescale 1ns/1ps
`default_nettype none

module slot_table (
    input  wire                               sys_clk,
    input  wire                               sys_rst_n,
    input  wire  [warehouse_pkg::LOC_W-1:0]   load_loc,
    input  wire  [warehouse_pkg::CODE_W-1:0]  load_shape,
    input  wire  [warehouse_pkg::CODE_W-1:0]  load_color,
    input  wire  [warehouse_pkg::CODE_W-1:0]  load_angle,
    input  wire                               load_valid,
    input  wire  [warehouse_pkg::LOC_W-1:0]   scan_index,
    input  wire                               claim,
    output logic [warehouse_pkg::CODE_W-1:0]  slot_color,
    output logic [warehouse_pkg::CODE_W-1:0]  slot_shape,
    output logic [warehouse_pkg::CODE_W-1:0]  slot_angle,
    output logic                              slot_used,
    output logic                              system_start
);

    import warehouse_pkg::*;

    logic [CODE_W-1:0]     color_mem [SLOT_COUNT];
    logic [CODE_W-1:0]     shape_mem [SLOT_COUNT];
    logic [CODE_W-1:0]     angle_mem [SLOT_COUNT];
    logic [SLOT_COUNT-1:0] used;

    logic             load_hit;
    logic             scan_hit;
    logic [LOC_W-1:0] load_idx;
    logic [LOC_W-1:0] scan_idx;

    // slots are numbered from 1
    assign load_hit = (load_loc != '0) && (load_loc <= LOC_W'(SLOT_COUNT));
    assign scan_hit = (scan_index != '0) && (scan_index <= LOC_W'(SLOT_COUNT));
    assign load_idx = load_loc - LOC_W'(1);
    assign scan_idx = scan_index - LOC_W'(1);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < SLOT_COUNT; i++) begin
                color_mem[i] <= '0;
                shape_mem[i] <= '0;
                angle_mem[i] <= '0;
            end
            used         <= '0;
            system_start <= 1'b0;
        end else begin
            if (load_valid && load_hit) begin  // occupancy untouched by a load
                color_mem[load_idx] <= load_color;
                shape_mem[load_idx] <= load_shape;
                angle_mem[load_idx] <= load_angle;
            end
            if (load_valid && (load_loc == START_LOC)) begin
                system_start <= 1'b1;  // sticky until reset
            end
            if (claim && scan_hit) begin
                used[scan_idx] <= 1'b1;
            end
        end
    end

    assign slot_color = scan_hit ? color_mem[scan_idx] : '0;
    assign slot_shape = scan_hit ? shape_mem[scan_idx] : '0;
    assign slot_angle = scan_hit ? angle_mem[scan_idx] : '0;
    assign slot_used  = scan_hit ? used[scan_idx] : 1'b0;

endmodule

`default_nettype wire

//--- slot_packet.sv
`timescale 1ns/1ps
`default_nettype none

module slot_packet (
    input  wire                               sys_clk,
    input  wire                               sys_rst_n,
    input  wire  [7:0]                        rx_byte,
    input  wire                               rx_strobe,
    output logic [warehouse_pkg::LOC_W-1:0]   load_loc,
    output logic [warehouse_pkg::CODE_W-1:0]  load_shape,
    output logic [warehouse_pkg::CODE_W-1:0]  load_color,
    output logic [warehouse_pkg::CODE_W-1:0]  load_angle,
    output logic                              load_valid
);

    import warehouse_pkg::*;

    localparam logic [1:0] B_HDR   = 2'd0;
    localparam logic [1:0] B_CODE  = 2'd1;
    localparam logic [1:0] B_ANGLE = 2'd2;

    logic [1:0] byte_pos;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            byte_pos   <= B_HDR;
            load_loc   <= '0;
            load_shape <= '0;
            load_color <= '0;
            load_angle <= '0;
            load_valid <= 1'b0;
        end else begin
            load_valid <= 1'b0;
            if (rx_strobe) begin
                case (byte_pos)
                    B_HDR: begin
                        if (rx_byte[7:5] == PKT_HDR) begin  // drop anything else
                            load_loc <= rx_byte[LOC_W-1:0];
                            byte_pos <= B_CODE;
                        end
                    end
                    B_CODE: begin
                        load_shape <= rx_byte[2*CODE_W-1:CODE_W];
                        load_color <= rx_byte[CODE_W-1:0];
                        byte_pos   <= B_ANGLE;
                    end
                    B_ANGLE: begin
                        load_angle <= rx_byte[CODE_W-1:0];
                        load_valid <= 1'b1;
                        byte_pos   <= B_HDR;
                    end
                    default: byte_pos <= B_HDR;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- uart_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_byte_rx #(
    parameter int CLKS_PER_BIT = 434
) (
    input  wire        sys_clk,
    input  wire        sys_rst_n,
    input  wire        uart_rx,
    output logic [7:0] rx_byte,
    output logic       rx_strobe
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [1:0]       rx_sync;
    logic             rx_line;
    logic [1:0]       state;
    logic [CNT_W-1:0] bit_cnt;  // clocks within current bit
    logic [2:0]       bit_idx;
    logic [7:0]       shift;

    assign rx_line = rx_sync[1];

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rx_sync <= 2'b11;  // line idles high
        end else begin
            rx_sync <= {rx_sync[0], uart_rx};
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state     <= S_IDLE;
            bit_cnt   <= '0;
            bit_idx   <= '0;
            shift     <= '0;
            rx_byte   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            case (state)
                S_IDLE: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_line) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (bit_cnt == HALF_BIT) begin
                        bit_cnt <= '0;
                        state   <= rx_line ? S_IDLE : S_DATA;  // glitch, not a start bit
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_cnt == FULL_BIT) begin
                        bit_cnt <= '0;
                        shift   <= {rx_line, shift[7:1]};  // lsb first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_cnt == FULL_BIT) begin
                        bit_cnt <= '0;
                        state   <= S_IDLE;
                        if (rx_line) begin
                            rx_byte   <= shift;
                            rx_strobe <= 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- warehouse_pkg.sv
`default_nettype none

package warehouse_pkg;

    localparam int SLOT_COUNT = 24;
    localparam int LOC_W      = 5;
    localparam int CODE_W     = 4;  // colour red 1 yellow 2 blue 4 black 8
    localparam int X_W        = 9;  // shape square 1 hexagon 2 circle 4 triangle 8
    localparam int Y_W        = 8;
    localparam int DIR_W      = 12;

    localparam logic [LOC_W-1:0] START_LOC = 5'h1F;
    localparam logic [2:0]       PKT_HDR   = 3'b101;

    localparam logic [DIR_W-1:0] DIR_0   = 12'd0;
    localparam logic [DIR_W-1:0] DIR_90  = 12'd1024;
    localparam logic [DIR_W-1:0] DIR_180 = 12'd2048;
    localparam logic [DIR_W-1:0] DIR_270 = 12'd3072;

    // rack positions, entry 0 is slot 1
    localparam logic [X_W-1:0] SLOT_X [SLOT_COUNT] = '{
        9'd255, 9'd255, 9'd253, 9'd255,  // column 1
        9'd210, 9'd210, 9'd210, 9'd210,
        9'd165, 9'd165, 9'd165, 9'd160,
        9'd120, 9'd120, 9'd120, 9'd120,
        9'd75,  9'd75,  9'd75,  9'd75,
        9'd32,  9'd32,  9'd32,  9'd28
    };

    localparam logic [Y_W-1:0] SLOT_Y [SLOT_COUNT] = '{
        8'd145, 8'd105, 8'd60,  8'd15,
        8'd150, 8'd105, 8'd68,  8'd15,
        8'd155, 8'd110, 8'd73,  8'd25,
        8'd160, 8'd115, 8'd70,  8'd32,
        8'd160, 8'd118, 8'd72,  8'd30,
        8'd164, 8'd119, 8'd74,  8'd31
    };

endpackage

`default_nettype wire
